// File: hw/triadCore_settings.svh
`ifndef TRIADCORE_SETTINGS_SVH
`define TRIADCORE_SETTINGS_SVH

// Address of the first fetched instruction
`define RESET_VECTOR 32'h0000_0000

// Instruction register contents before the first fetch
`define INSN_NOOP 32'h0000_0000

// Word address width of the unified memory, 1024 words
`define MEM_ADDR_BITS 10

// All-ones word is illegal and stops the core
`define INSN_HALT 32'hffff_ffff

`endif

// File: hw/triadPkg.sv
package triadPkg;

    typedef logic [31:0] word_t;    // Machine word
    typedef logic [3:0] regIndex_t; // Register number

    // Operation codes, instruction bits 15:12
    typedef enum logic [3:0] {
        opOr    = 4'h0,
        opAnd   = 4'h1,
        opAdd   = 4'h2,
        opMul   = 4'h3,
        opRes4  = 4'h4,  // Reserved
        opShl   = 4'h5,
        opLt    = 4'h6,
        opEq    = 4'h7,
        opGt    = 4'h8,
        opAndn  = 4'h9,
        opXor   = 4'ha,
        opSub   = 4'hb,
        opXnor  = 4'hc,
        opShr   = 4'hd,
        opNe    = 4'he,
        opRes15 = 4'hf   // Reserved
    } aluOp_t;

    // Start-up states, then the seven-cycle instruction rhythm
    typedef enum logic [3:0] {
        stInit0,
        stInit1,
        stInit2,
        stInit3,
        stFetchWait,
        stDecode,
        stExecute,
        stAccess,
        stCapture,
        stRedirect,
        stCommit,
        stHalted
    } seqState_t;

endpackage

// File: hw/registerFile.sv
module registerFile
    import triadPkg::*;
(
    input  logic      clk,
    input  logic      writeEnable,
    input  regIndex_t indexX,
    input  regIndex_t indexY,
    input  regIndex_t indexZ,
    input  word_t     writeData,
    input  word_t     nextPc,
    output word_t     valueX,
    output word_t     valueY,
    output word_t     valueZ
);

    word_t regArray [1:14]; // Registers 0 and 15 are not stored

    function automatic word_t readPort(input regIndex_t index);
        word_t value;
        if (index == 4'd0)
            value = '0;
        else if (index == 4'd15)
            value = nextPc;          // Program counter view
        else
            value = regArray[index];
        return value;
    endfunction

    assign valueX = readPort(indexX);
    assign valueY = readPort(indexY);
    assign valueZ = readPort(indexZ);

    always_ff @(posedge clk) begin
        if (writeEnable && indexZ != 4'd0 && indexZ != 4'd15)
            regArray[indexZ] <= writeData;
    end

    // Branches never reach the array, the sequencer redirects the fetch instead
    branchNotWritten: assert property (@(posedge clk) writeEnable |-> indexZ != 4'd15);

endmodule

// File: hw/instructionDecoder.sv
`include "triadCore_settings.svh"

module instructionDecoder
    import triadPkg::*;
(
    input  word_t     insn,
    output regIndex_t indexZ,
    output regIndex_t indexX,
    output regIndex_t indexY,
    output aluOp_t    op,
    output word_t     immediate,
    output logic      swap,
    output logic      storing,
    output logic      deref,
    output logic      illegal,
    output logic      branch
);

    logic [11:0] shortImm;

    assign swap     = insn[30];
    assign storing  = insn[29];
    assign deref    = insn[28];
    assign indexZ   = insn[27:24];
    assign indexX   = insn[23:20];
    assign indexY   = insn[19:16];
    assign op       = aluOp_t'(insn[15:12]);
    assign shortImm = insn[11:0];

    assign immediate = {{20{shortImm[11]}}, shortImm}; // Sign extend

    assign illegal = insn == `INSN_HALT;
    assign branch  = indexZ == 4'd15 && !storing;   // Write to PC

endmodule

// File: hw/arithmeticUnit.sv
module arithmeticUnit
    import triadPkg::*;
(
    input  logic   clk,
    input  logic   enable,
    input  aluOp_t op,
    input  logic   swap,
    input  word_t  valueX,
    input  word_t  valueY,
    input  word_t  immediate,
    output word_t  result
);

    word_t operand;
    word_t addend;
    word_t opResult;

    // Swap exchanges the roles of Y and the immediate
    assign operand = swap ? immediate : valueY;
    assign addend  = swap ? valueY : immediate;

    always_comb begin
        case (op)
            opOr:    opResult = valueX | operand;
            opAnd:   opResult = valueX & operand;
            opAdd:   opResult = valueX + operand;
            opMul:   opResult = valueX * operand;
            opShl:   opResult = valueX << operand;
            opLt:    opResult = {32{$signed(valueX) < $signed(operand)}};
            opEq:    opResult = {32{valueX == operand}};
            opGt:    opResult = {32{$signed(valueX) > $signed(operand)}};
            opAndn:  opResult = valueX & ~operand;
            opXor:   opResult = valueX ^ operand;
            opSub:   opResult = valueX - operand;
            opXnor:  opResult = valueX ^~ operand;
            opShr:   opResult = valueX >> operand;   // Logical
            opNe:    opResult = {32{valueX != operand}};
            default: opResult = '0;                  // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable)
            result <= opResult + addend;
    end

endmodule

// File: hw/coreSequencer.sv
`include "triadCore_settings.svh"

module coreSequencer
    import triadPkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  hold,
    output logic  loadReady,
    output logic  halted,
    output word_t fetchAddr,
    input  word_t fetchData,
    output word_t dataAddr,
    output logic  dataStrobe,
    output logic  dataWrite,
    output word_t dataWriteData,
    input  word_t dataReadData
);

    seqState_t state;
    logic      haltLatch;
    word_t     insn;
    word_t     nextPc;
    word_t     loadData;

    regIndex_t indexX;
    regIndex_t indexY;
    regIndex_t indexZ;
    aluOp_t    op;
    word_t     immediate;
    logic      swap;
    logic      storing;
    logic      deref;
    logic      illegal;
    logic      branch;

    word_t valueX;
    word_t valueY;
    word_t valueZ;
    word_t result;
    word_t rhs;
    logic  loading;
    logic  execEnable;
    logic  writeEnable;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= stInit0;
            haltLatch <= 1'b0;
        end else begin
            case (state)
                stInit0:     state <= hold ? stInit0 : stInit1;
                stInit1:     state <= stInit2;
                stInit2:     state <= stInit3;
                stInit3:     state <= stFetchWait;
                stFetchWait: state <= hold ? stFetchWait : stDecode;
                stDecode: begin
                    if (illegal) begin
                        state     <= stHalted;  // Stays until reset
                        haltLatch <= 1'b1;
                    end else begin
                        state <= stExecute;
                    end
                end
                stExecute:   state <= stAccess;
                stAccess:    state <= stCapture;
                stCapture:   state <= stRedirect;
                stRedirect:  state <= stCommit;
                stCommit:    state <= stFetchWait;
                stHalted:    state <= stHalted;
                default:     state <= stInit0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            stInit0: begin
                fetchAddr <= `RESET_VECTOR;
                insn      <= `INSN_NOOP;
                nextPc    <= `RESET_VECTOR + 32'd1;
            end
            stFetchWait: insn      <= fetchData;               // Memory read is ready here
            stCapture:   loadData  <= dataReadData;
            stRedirect:  fetchAddr <= branch ? rhs : nextPc;
            stCommit:    nextPc    <= fetchAddr + 32'd1;
            default: ;
        endcase
    end

    assign halted    = haltLatch;
    assign loadReady = hold && (state == stInit0 || state == stFetchWait);

    instructionDecoder i_instructionDecoder (
        .insn      (insn),
        .indexZ    (indexZ),
        .indexX    (indexX),
        .indexY    (indexY),
        .op        (op),
        .immediate (immediate),
        .swap      (swap),
        .storing   (storing),
        .deref     (deref),
        .illegal   (illegal),
        .branch    (branch)
    );

    assign execEnable = state == stExecute;

    arithmeticUnit i_arithmeticUnit (
        .clk       (clk),
        .enable    (execEnable),
        .op        (op),
        .swap      (swap),
        .valueX    (valueX),
        .valueY    (valueY),
        .immediate (immediate),
        .result    (result)
    );

    // Deref turns the result into an address
    assign loading       = deref && !storing;
    assign dataStrobe    = state == stAccess && (loading || storing);
    assign dataWrite     = dataStrobe && storing;
    assign dataAddr      = deref ? result : valueZ;
    assign dataWriteData = deref ? valueZ : result;
    assign rhs           = deref ? loadData : result;

    // A branch only redirects the fetch
    assign writeEnable = state == stCommit && !storing && !branch;

    registerFile i_registerFile (
        .clk         (clk),
        .writeEnable (writeEnable),
        .indexX      (indexX),
        .indexY      (indexY),
        .indexZ      (indexZ),
        .writeData   (rhs),
        .nextPc      (nextPc),
        .valueX      (valueX),
        .valueY      (valueY),
        .valueZ      (valueZ)
    );

endmodule

// File: hw/unifiedMemory.sv
`include "triadCore_settings.svh"

module unifiedMemory
    import triadPkg::*;
(
    input  logic  clk,
    input  word_t fetchAddr,
    output word_t fetchData,
    input  word_t dataAddr,
    input  logic  dataStrobe,
    input  logic  dataWrite,
    input  word_t dataWriteData,
    output word_t dataReadData,
    input  logic  loadValid,
    input  logic  loadReady,
    input  word_t loadAddr,
    input  word_t loadData
);

    word_t memArray [2**`MEM_ADDR_BITS];

    logic                      loadWrite;
    logic                      writeEnable;
    logic [`MEM_ADDR_BITS-1:0] writeIndex;
    word_t                     writeValue;

    assign loadWrite   = loadValid && loadReady;   // Handshake beat
    assign writeEnable = loadWrite || (dataStrobe && dataWrite);
    assign writeIndex  = loadWrite ? loadAddr[`MEM_ADDR_BITS-1:0]
                                   : dataAddr[`MEM_ADDR_BITS-1:0];
    assign writeValue  = loadWrite ? loadData : dataWriteData;

    always_ff @(posedge clk) begin
        fetchData <= memArray[fetchAddr[`MEM_ADDR_BITS-1:0]]; // Upper bits ignored
        if (dataStrobe)
            dataReadData <= memArray[dataAddr[`MEM_ADDR_BITS-1:0]];
        if (writeEnable)
            memArray[writeIndex] <= writeValue;
    end

    // Program load only happens while the core is parked
    loadDataExclusive: assert property (@(posedge clk)
        !(loadWrite && dataStrobe && dataWrite));

endmodule

// File: hw/triadSystem.sv
module triadSystem
    import triadPkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  hold,
    input  logic  loadValid,
    output logic  loadReady,
    input  word_t loadAddr,
    input  word_t loadData,
    output logic  storeStrobe,
    output word_t storeAddr,
    output word_t storeData,
    output logic  halted
);

    word_t fetchAddr;
    word_t fetchData;
    word_t dataReadData;
    logic  dataStrobe;

    // Store outputs are the data port write itself
    coreSequencer i_coreSequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .hold          (hold),
        .loadReady     (loadReady),
        .halted        (halted),
        .fetchAddr     (fetchAddr),
        .fetchData     (fetchData),
        .dataAddr      (storeAddr),
        .dataStrobe    (dataStrobe),
        .dataWrite     (storeStrobe),
        .dataWriteData (storeData),
        .dataReadData  (dataReadData)
    );

    unifiedMemory i_unifiedMemory (
        .clk           (clk),
        .fetchAddr     (fetchAddr),
        .fetchData     (fetchData),
        .dataAddr      (storeAddr),
        .dataStrobe    (dataStrobe),
        .dataWrite     (storeStrobe),
        .dataWriteData (storeData),
        .dataReadData  (dataReadData),
        .loadValid     (loadValid),
        .loadReady     (loadReady),
        .loadAddr      (loadAddr),
        .loadData      (loadData)
    );

endmodule

// File: verification/triadSystemTb.sv
`include "triadCore_settings.svh"

module triadSystemTb
    import triadPkg::*;
();

    localparam int NUM_PROGRAMS = 3;
    localparam int MAX_LEN      = 512;   // Program region below the data at 512
    localparam int LIMIT        = (MAX_LEN * 7 + 200 + MAX_LEN * 2) * NUM_PROGRAMS;

    logic  clk = 1'b0;
    logic  reset_n, hold, loadValid, loadReady, storeStrobe, halted;
    word_t loadAddr, loadData, storeAddr, storeData;

    word_t      lfsr;
    word_t      prog [MAX_LEN];
    int         progLen;
    word_t      regs [16];           // ISA model state
    word_t      dataMem [1024];
    word_t      pc;
    logic [9:0] storedAddrs [$];
    word_t      expAddr [$];
    word_t      expData [$];
    int         expIdx [$];
    int         execCount = 0;
    int         cycleCount = 0;
    int         lastCycle, lastIdx;
    bit         haveLast;

    triadSystem i_triadSystem (
        .clk(clk), .reset_n(reset_n), .hold(hold), .loadValid(loadValid),
        .loadReady(loadReady), .loadAddr(loadAddr), .loadData(loadData),
        .storeStrobe(storeStrobe), .storeAddr(storeAddr), .storeData(storeData),
        .halted(halted)
    );

    always #10 clk = ~clk;
    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input word_t got, input word_t exp);
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic word_t randomBits(input int width);
        word_t value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return value;
    endfunction

    function automatic logic [3:0] randomOp();
        logic [3:0] code = 4'(randomBits(4));
        if (code == 4'h4)
            code = 4'h2;     // Reserved codes are not generated
        else if (code == 4'hf)
            code = 4'hb;
        return code;
    endfunction

    function automatic logic [11:0] dataImm();
        return {3'b001, 9'(randomBits(9))};   // 0x200 to 0x3ff
    endfunction

    function automatic word_t makeInsn(input bit sw, input bit st, input bit dr,
            input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
            input logic [3:0] op, input logic [11:0] imm);
        return {1'b0, sw, st, dr, z, x, y, op, imm};
    endfunction

    function automatic word_t readReg(input logic [3:0] idx);
        if (idx == 4'd0)
            return '0;
        if (idx == 4'd15)
            return pc + 32'd1;    // Next instruction address
        return regs[idx];
    endfunction

    function automatic word_t applyOperation(input logic [3:0] op, input word_t a, input word_t b);
        case (aluOp_t'(op))
            opOr:    return a | b;
            opAnd:   return a & b;
            opAdd:   return a + b;
            opMul:   return a * b;
            opShl:   return (b >= 32) ? '0 : a << b[4:0];
            opLt:    return ($signed(a) < $signed(b)) ? '1 : '0;
            opEq:    return (a == b) ? '1 : '0;
            opGt:    return ($signed(a) > $signed(b)) ? '1 : '0;
            opAndn:  return a & ~b;
            opXor:   return a ^ b;
            opSub:   return a - b;
            opXnor:  return ~(a ^ b);
            opShr:   return (b >= 32) ? '0 : a >> b[4:0];
            opNe:    return (a != b) ? '1 : '0;
            default: return '0;
        endcase
    endfunction

    // Append one word, and run it on the model when it is on the taken path
    task automatic emit(input word_t insn, input bit live);
        word_t x, y, z, imm, res, value;
        prog[progLen] = insn;
        progLen++;
        if (live) begin
            x   = readReg(insn[23:20]);
            y   = readReg(insn[19:16]);
            z   = readReg(insn[27:24]);
            imm = {{20{insn[11]}}, insn[11:0]};
            res = applyOperation(insn[15:12], x, insn[30] ? imm : y) + (insn[30] ? y : imm);
            if (insn[29]) begin
                expAddr.push_back(insn[28] ? res : z);
                expData.push_back(insn[28] ? z : res);
                expIdx.push_back(execCount);
                dataMem[expAddr[$][9:0]] = expData[$];
                storedAddrs.push_back(expAddr[$][9:0]);
                pc = pc + 32'd1;
            end else begin
                value = insn[28] ? dataMem[res[9:0]] : res;
                if (insn[27:24] == 4'd15) begin
                    pc = value;                       // Branch
                end else begin
                    if (insn[27:24] != 4'd0)
                        regs[insn[27:24]] = value;
                    pc = pc + 32'd1;
                end
            end
            execCount++;
        end
    endtask

    task automatic storePair(input logic [3:0] op, input bit sw);
        logic [3:0] a = 4'(1 + randomBits(4) % 14);
        emit(makeInsn(0, 0, 0, a, 4'd0, 4'd0, 4'h0, dataImm()), 1);
        emit(makeInsn(sw, 1, 0, a, 4'(randomBits(4)), 4'(randomBits(4)), op,
            12'(randomBits(12))), 1);
    endtask

    task automatic buildProgram();
        int skip;
        progLen = 0;
        pc      = '0;
        for (int r = 1; r < 15; r++)
            emit(makeInsn(0, 0, 0, 4'(r), 4'd0, 4'd0, 4'h0, 12'(randomBits(12))), 1);
        for (int op = 0; op < 16; op++)
            for (int sw = 0; sw < 2; sw++)
                if (op != 4 && op != 15)
                    storePair(4'(op), sw[0]);    // Every opcode with both swaps
        while (progLen < 440) begin
            case (randomBits(3))
                2: storePair(randomOp(), randomBits(1) != 0);
                3: emit(makeInsn(0, 1, 1, 4'(randomBits(4)), 4'd0, 4'd0, 4'h0, dataImm()), 1);
                4: emit(makeInsn(0, 0, 1, 4'(1 + randomBits(4) % 14), 4'd0, 4'd0, 4'h0,
                       {2'b00, storedAddrs[randomBits(8) % storedAddrs.size()]}), 1);
                5: begin
                    skip = 1 + int'(randomBits(2) % 3);
                    emit(makeInsn(0, 0, 0, 4'd15, 4'd0, 4'd0, 4'h0, 12'(progLen + 1 + skip)), 1);
                    repeat (skip)
                        emit(makeInsn(0, 1, 1, 4'(randomBits(4)), 4'd0, 4'd0, 4'h0, dataImm()), 0);
                end
                default: emit(makeInsn(randomBits(1) != 0, 0, 0, 4'(1 + randomBits(4) % 14),
                    4'(randomBits(4)), 4'(randomBits(4)), randomOp(), 12'(randomBits(12))), 1);
            endcase
        end
        emit(`INSN_HALT, 0);
    endtask

    // Dropped beats carry a decoy for the previous word
    task automatic loadProgram();
        int  i = 0;
        bit  accepted;
        while (i < progLen) begin
            loadValid = randomBits(2) != 0;
            loadAddr  = loadValid ? word_t'(i) : word_t'(i > 0 ? i - 1 : 0);
            loadData  = loadValid ? prog[i] : ~prog[i > 0 ? i - 1 : 0];
            @(negedge clk);
            assert (loadReady && !halted)
                else abortRun("core left the parked state during program load");
            accepted = loadValid && loadReady;
            @(posedge clk);
            #1;
            if (accepted)
                i++;
        end
        loadValid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset_n) begin
            haveLast = 1'b0;
        end else if (storeStrobe) begin
            assert (expAddr.size() > 0) else abortRun("store seen where the model expects none");
            assert (storeAddr == expAddr[0])
                else reportMismatch("storeAddr", storeAddr, expAddr[0]);
            assert (storeData == expData[0])
                else reportMismatch("storeData", storeData, expData[0]);
            if (haveLast) begin
                assert (cycleCount - lastCycle == 7 * (expIdx[0] - lastIdx))
                    else abortRun("store spacing is not seven cycles per instruction");
            end
            haveLast  = 1'b1;
            lastCycle = cycleCount;
            lastIdx   = expIdx[0];
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            void'(expIdx.pop_front());
        end
    end

    initial begin
        #(LIMIT * 20);
        abortRun("watchdog expired, the run took too long");
    end

    initial begin
        int n;
        lfsr      = 32'h9c21_7df9;
        reset_n   = 1'b0;
        hold      = 1'b1;
        loadValid = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            reset_n  = 1'b0;
            hold     = 1'b1;
            buildProgram();
            repeat (2) @(posedge clk);
            #1 reset_n = 1'b1;
            @(negedge clk);
            assert (!halted && !storeStrobe && loadReady)
                else abortRun("core is not parked and ready after reset");
            @(posedge clk);
            #1;
            loadProgram();
            hold = 1'b0;
            n = 0;
            while (!halted) begin
                @(negedge clk);
                n++;
                assert (n < progLen * 7 + 200) else abortRun("core did not reach the halt word");
            end
            repeat (20) @(posedge clk);   // No store may follow the halt
            #1;
            assert (expAddr.size() == 0) else abortRun("expected stores never appeared");
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: triadCore.f
+incdir+hw
hw/triadPkg.sv
hw/registerFile.sv
hw/instructionDecoder.sv
hw/arithmeticUnit.sv
hw/coreSequencer.sv
hw/unifiedMemory.sv
hw/triadSystem.sv
verification/triadSystemTb.sv

// File: runSim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f triadCore.f --top-module triadSystemTb -o triadSim

output=$(./obj_dir/triadSim)
echo "$output"
echo "$output" | grep -q "TEST PASSED"
